//--- id_pkg.sv
package id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [3:0]  exc_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {SRC1_REG, SRC1_SA, SRC1_PC} src1_sel_e;
	typedef enum logic [1:0] {SRC2_REG, SRC2_IMM_S, SRC2_IMM_U, SRC2_EIGHT} src2_sel_e;
	typedef enum logic [1:0] {WADDR_RD, WADDR_RT, WADDR_LINK} waddr_sel_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_JIMM, BR_JREG
	} branch_kind_e;

	// exc_t bit positions
	localparam int EXC_FETCH   = 0;
	localparam int EXC_SYSCALL = 1;
	localparam int EXC_BREAK   = 2;
	localparam int EXC_RI      = 3;

	localparam reg_addr_t LINK_REG    = 5'd31;
	localparam word_t     LINK_OFFSET = 32'd8;

	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_REGIMM  = 6'h01;
	localparam opcode_t OP_J       = 6'h02;
	localparam opcode_t OP_JAL     = 6'h03;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_BNE     = 6'h05;
	localparam opcode_t OP_BLEZ    = 6'h06;
	localparam opcode_t OP_BGTZ    = 6'h07;
	localparam opcode_t OP_ADDI    = 6'h08;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_SLTI    = 6'h0a;
	localparam opcode_t OP_SLTIU   = 6'h0b;
	localparam opcode_t OP_ANDI    = 6'h0c;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_XORI    = 6'h0e;
	localparam opcode_t OP_LUI     = 6'h0f;

	localparam funct_t F_SLL     = 6'h00;
	localparam funct_t F_SRL     = 6'h02;
	localparam funct_t F_SRA     = 6'h03;
	localparam funct_t F_SLLV    = 6'h04;
	localparam funct_t F_SRLV    = 6'h06;
	localparam funct_t F_SRAV    = 6'h07;
	localparam funct_t F_JR      = 6'h08;
	localparam funct_t F_JALR    = 6'h09;
	localparam funct_t F_SYSCALL = 6'h0c;
	localparam funct_t F_BREAK   = 6'h0d;
	localparam funct_t F_ADD     = 6'h20;
	localparam funct_t F_ADDU    = 6'h21;
	localparam funct_t F_SUB     = 6'h22;
	localparam funct_t F_SUBU    = 6'h23;
	localparam funct_t F_AND     = 6'h24;
	localparam funct_t F_OR      = 6'h25;
	localparam funct_t F_XOR     = 6'h26;
	localparam funct_t F_NOR     = 6'h27;
	localparam funct_t F_SLT     = 6'h2a;
	localparam funct_t F_SLTU    = 6'h2b;

	// regimm branches are told apart by the rt field
	localparam reg_addr_t RT_BLTZ   = 5'h00;
	localparam reg_addr_t RT_BGEZ   = 5'h01;
	localparam reg_addr_t RT_BLTZAL = 5'h10;
	localparam reg_addr_t RT_BGEZAL = 5'h11;

endpackage

//--- id_ctrl_if.sv
`timescale 1ns/1ps

interface id_ctrl_if;

	id_pkg::alu_op_e      aluop;
	id_pkg::src1_sel_e    src1_sel;
	id_pkg::src2_sel_e    src2_sel;
	id_pkg::waddr_sel_e   waddr_sel;
	logic                 wren;
	id_pkg::branch_kind_e branch_kind;
	logic                 link;     // return address pair goes to ex
	logic                 ov_inst;  // may overflow in ex
	id_pkg::exc_t         exc;

	modport ctrl (
		output aluop, src1_sel, src2_sel, waddr_sel, wren,
		output branch_kind, link, ov_inst, exc
	);

	modport opsel (input src1_sel, src2_sel, waddr_sel, link);

	modport branch (input branch_kind);

	modport pipe (input aluop, wren, ov_inst, exc);

endinterface

//--- id_control.sv
`timescale 1ns/1ps

module id_control (
	input  id_pkg::word_t inst_i,
	input  logic          valid_i,
	input  logic          fetch_exc_i,
	output logic          rs_ren_o,
	output logic          rt_ren_o,
	id_ctrl_if.ctrl       ctrl
);

	id_pkg::opcode_t      opcode;
	id_pkg::funct_t       funct;
	id_pkg::reg_addr_t    rt;
	logic                 rs_zero;
	logic                 rt_zero;
	logic                 rd_zero;
	logic                 sa_zero;
	logic                 known;
	logic                 wr;
	logic                 lnk;
	logic                 ov;
	logic                 is_sys;
	logic                 is_brk;
	logic                 rs_ren;
	logic                 rt_ren;
	id_pkg::branch_kind_e kind;

	assign opcode  = inst_i[31:26];
	assign funct   = inst_i[5:0];
	assign rt      = inst_i[20:16];
	assign rs_zero = (inst_i[25:21] == 5'd0);
	assign rt_zero = (rt == 5'd0);
	assign rd_zero = (inst_i[15:11] == 5'd0);
	assign sa_zero = (inst_i[10:6] == 5'd0);

	always_comb begin
		known          = 1'b1;
		wr             = 1'b1;
		lnk            = 1'b0;
		ov             = 1'b0;
		is_sys         = 1'b0;
		is_brk         = 1'b0;
		rs_ren         = 1'b1;
		rt_ren         = 1'b0;
		kind           = id_pkg::BR_NONE;
		ctrl.aluop     = id_pkg::ALU_ADD;
		ctrl.src1_sel  = id_pkg::SRC1_REG;
		ctrl.src2_sel  = id_pkg::SRC2_REG;
		ctrl.waddr_sel = id_pkg::WADDR_RD;
		case (opcode)
		id_pkg::OP_SPECIAL: begin
			rt_ren = 1'b1;
			known  = sa_zero;  // most r-type want sa == 0
			case (funct)
			id_pkg::F_ADD, id_pkg::F_ADDU, id_pkg::F_SUB, id_pkg::F_SUBU: begin
				ctrl.aluop = funct[1] ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
				ov         = ~funct[0];  // signed forms only
			end
			id_pkg::F_SLT:  ctrl.aluop = id_pkg::ALU_SLT;
			id_pkg::F_SLTU: ctrl.aluop = id_pkg::ALU_SLTU;
			id_pkg::F_AND:  ctrl.aluop = id_pkg::ALU_AND;
			id_pkg::F_OR:   ctrl.aluop = id_pkg::ALU_OR;
			id_pkg::F_XOR:  ctrl.aluop = id_pkg::ALU_XOR;
			id_pkg::F_NOR:  ctrl.aluop = id_pkg::ALU_NOR;
			id_pkg::F_SLL, id_pkg::F_SRL, id_pkg::F_SRA,
			id_pkg::F_SLLV, id_pkg::F_SRLV, id_pkg::F_SRAV: begin
				ctrl.aluop = funct[1] ? (funct[0] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL)
					: id_pkg::ALU_SLL;
				if (!funct[2]) begin  // shift by sa
					known         = rs_zero;
					rs_ren        = 1'b0;
					ctrl.src1_sel = id_pkg::SRC1_SA;
				end
			end
			id_pkg::F_JR, id_pkg::F_JALR: begin
				known  = sa_zero & rt_zero & (funct[0] | rd_zero);
				rt_ren = 1'b0;
				wr     = 1'b0;
				lnk    = funct[0];  // jalr writes rd
				kind   = id_pkg::BR_JREG;
			end
			id_pkg::F_SYSCALL, id_pkg::F_BREAK: begin
				known  = 1'b1;
				rs_ren = 1'b0;
				rt_ren = 1'b0;
				wr     = 1'b0;
				is_sys = ~funct[0];
				is_brk = funct[0];
			end
			default: known = 1'b0;
			endcase
		end
		id_pkg::OP_REGIMM: begin
			wr             = 1'b0;
			lnk            = rt[4];
			ctrl.waddr_sel = id_pkg::WADDR_LINK;
			case (rt)
			id_pkg::RT_BLTZ, id_pkg::RT_BLTZAL: kind = id_pkg::BR_BLTZ;
			id_pkg::RT_BGEZ, id_pkg::RT_BGEZAL: kind = id_pkg::BR_BGEZ;
			default: known = 1'b0;
			endcase
		end
		id_pkg::OP_J, id_pkg::OP_JAL: begin
			rs_ren         = 1'b0;
			wr             = 1'b0;
			lnk            = opcode[0];
			kind           = id_pkg::BR_JIMM;
			ctrl.waddr_sel = id_pkg::WADDR_LINK;
		end
		id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
			rt_ren = 1'b1;
			wr     = 1'b0;
			kind   = opcode[0] ? id_pkg::BR_BNE : id_pkg::BR_BEQ;
		end
		id_pkg::OP_BLEZ, id_pkg::OP_BGTZ: begin
			known = rt_zero;
			wr    = 1'b0;
			kind  = opcode[0] ? id_pkg::BR_BGTZ : id_pkg::BR_BLEZ;
		end
		id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
			ctrl.src2_sel  = id_pkg::SRC2_IMM_S;
			ctrl.waddr_sel = id_pkg::WADDR_RT;
			ov             = (opcode == id_pkg::OP_ADDI);
			case (opcode[1:0])
			2'b10:   ctrl.aluop = id_pkg::ALU_SLT;
			2'b11:   ctrl.aluop = id_pkg::ALU_SLTU;
			default: ctrl.aluop = id_pkg::ALU_ADD;
			endcase
		end
		id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
			ctrl.src2_sel  = id_pkg::SRC2_IMM_U;
			ctrl.waddr_sel = id_pkg::WADDR_RT;
			case (opcode[1:0])
			2'b00:   ctrl.aluop = id_pkg::ALU_AND;
			2'b01:   ctrl.aluop = id_pkg::ALU_OR;
			2'b10:   ctrl.aluop = id_pkg::ALU_XOR;
			default: begin
				ctrl.aluop = id_pkg::ALU_LUI;
				known      = rs_zero;
				rs_ren     = 1'b0;
			end
			endcase
		end
		default: begin
			known  = 1'b0;
			rs_ren = 1'b0;
		end
		endcase
	end

	assign rs_ren_o         = rs_ren & known;
	assign rt_ren_o         = rt_ren & known;
	assign ctrl.wren        = valid_i & known & (wr | lnk);
	assign ctrl.link        = known & lnk;
	assign ctrl.ov_inst     = valid_i & known & ov;
	assign ctrl.branch_kind = (valid_i && known) ? kind : id_pkg::BR_NONE;

	always_comb begin
		ctrl.exc                     = '0;
		ctrl.exc[id_pkg::EXC_FETCH]   = valid_i & fetch_exc_i;
		ctrl.exc[id_pkg::EXC_SYSCALL] = valid_i & known & is_sys;
		ctrl.exc[id_pkg::EXC_BREAK]   = valid_i & known & is_brk;
		ctrl.exc[id_pkg::EXC_RI]      = valid_i & ~known;
	end

endmodule

//--- id_operand_select.sv
`timescale 1ns/1ps

module id_operand_select (
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     rs_data_i,
	input  id_pkg::word_t     rt_data_i,
	id_ctrl_if.opsel          sel,
	output id_pkg::word_t     opr1_o,
	output id_pkg::word_t     opr2_o,
	output id_pkg::reg_addr_t waddr_o
);

	id_pkg::word_t     sign_ext;
	id_pkg::word_t     zero_ext;
	id_pkg::word_t     upper_ext;
	id_pkg::word_t     sa_ext;
	logic              is_lui;
	id_pkg::src1_sel_e src1;
	id_pkg::src2_sel_e src2;

	assign sign_ext  = {{16{inst_i[15]}}, inst_i[15:0]};
	assign zero_ext  = {16'h0, inst_i[15:0]};
	assign upper_ext = {inst_i[15:0], 16'h0};
	assign sa_ext    = {27'h0, inst_i[10:6]};
	assign is_lui    = (inst_i[31:26] == id_pkg::OP_LUI);

	// link forms send pc and 8 so ex adds up the return address
	assign src1 = sel.link ? id_pkg::SRC1_PC : sel.src1_sel;
	assign src2 = sel.link ? id_pkg::SRC2_EIGHT : sel.src2_sel;

	always_comb begin
		case (src1)
		id_pkg::SRC1_SA: opr1_o = sa_ext;
		id_pkg::SRC1_PC: opr1_o = pc_i;
		default:         opr1_o = rs_data_i;
		endcase
	end

	always_comb begin
		case (src2)
		id_pkg::SRC2_IMM_S: opr2_o = sign_ext;
		id_pkg::SRC2_IMM_U: opr2_o = is_lui ? upper_ext : zero_ext;
		id_pkg::SRC2_EIGHT: opr2_o = id_pkg::LINK_OFFSET;
		default:            opr2_o = rt_data_i;
		endcase
	end

	always_comb begin
		case (sel.waddr_sel)
		id_pkg::WADDR_RT:   waddr_o = inst_i[20:16];
		id_pkg::WADDR_LINK: waddr_o = id_pkg::LINK_REG;
		default:            waddr_o = inst_i[15:11];
		endcase
	end

endmodule

//--- id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit (
	input  id_pkg::word_t inst_i,
	input  id_pkg::word_t pc_i,
	input  id_pkg::word_t rs_data_i,
	input  id_pkg::word_t rt_data_i,
	id_ctrl_if.branch     br,
	output logic          branch_en_o,
	output id_pkg::word_t branch_pc_o
);

	id_pkg::word_t pcp4;
	id_pkg::word_t sign_ext;
	id_pkg::word_t b_target;
	id_pkg::word_t j_target;
	logic          eq;
	logic          ltz;
	logic          lez;

	assign pcp4     = pc_i + 32'd4;
	assign sign_ext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign b_target = pcp4 + {sign_ext[29:0], 2'b00};
	assign j_target = {pcp4[31:28], inst_i[25:0], 2'b00};  // stays in the 256MB region

	assign eq  = (rs_data_i == rt_data_i);
	assign ltz = rs_data_i[31];
	assign lez = ltz | (rs_data_i == 32'd0);

	always_comb begin
		case (br.branch_kind)
		id_pkg::BR_BEQ:  branch_en_o = eq;
		id_pkg::BR_BNE:  branch_en_o = ~eq;
		id_pkg::BR_BGEZ: branch_en_o = ~ltz;
		id_pkg::BR_BGTZ: branch_en_o = ~lez;
		id_pkg::BR_BLEZ: branch_en_o = lez;
		id_pkg::BR_BLTZ: branch_en_o = ltz;
		id_pkg::BR_JIMM, id_pkg::BR_JREG: branch_en_o = 1'b1;
		default:         branch_en_o = 1'b0;
		endcase
	end

	always_comb begin
		case (br.branch_kind)
		id_pkg::BR_NONE: branch_pc_o = '0;
		id_pkg::BR_JIMM: branch_pc_o = j_target;
		id_pkg::BR_JREG: branch_pc_o = rs_data_i;
		default:         branch_pc_o = b_target;
		endcase
	end

endmodule

//--- id_pipe_reg.sv
`timescale 1ns/1ps

module id_pipe_reg (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              stall_i,
	input  logic              flush_i,
	input  logic              valid_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     opr1_i,
	input  id_pkg::word_t     opr2_i,
	input  id_pkg::word_t     rt_data_i,
	input  id_pkg::reg_addr_t waddr_i,
	id_ctrl_if.pipe           pl,
	output logic              ex_valid_o,
	output id_pkg::word_t     ex_pc_o,
	output id_pkg::word_t     ex_opr1_o,
	output id_pkg::word_t     ex_opr2_o,
	output id_pkg::word_t     ex_rtvalue_o,
	output id_pkg::alu_op_e   ex_aluop_o,
	output logic              ex_wren_o,
	output id_pkg::reg_addr_t ex_waddr_o,
	output id_pkg::exc_t      ex_exc_o,
	output logic              ex_has_exc_o,
	output logic              ex_ov_inst_o
);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid_o   <= 1'b0;
			ex_pc_o      <= '0;
			ex_opr1_o    <= '0;
			ex_opr2_o    <= '0;
			ex_rtvalue_o <= '0;
			ex_aluop_o   <= id_pkg::ALU_ADD;
			ex_wren_o    <= 1'b0;
			ex_waddr_o   <= '0;
			ex_exc_o     <= '0;
			ex_has_exc_o <= 1'b0;
			ex_ov_inst_o <= 1'b0;
		end else if (!stall_i) begin  // stall wins over flush
			if (flush_i) begin
				ex_valid_o   <= 1'b0;
				ex_pc_o      <= '0;
				ex_opr1_o    <= '0;
				ex_opr2_o    <= '0;
				ex_rtvalue_o <= '0;
				ex_aluop_o   <= id_pkg::ALU_ADD;
				ex_wren_o    <= 1'b0;
				ex_waddr_o   <= '0;
				ex_exc_o     <= '0;
				ex_has_exc_o <= 1'b0;
				ex_ov_inst_o <= 1'b0;
			end else begin
				ex_valid_o   <= valid_i;
				ex_pc_o      <= pc_i;
				ex_opr1_o    <= opr1_i;
				ex_opr2_o    <= opr2_i;
				ex_rtvalue_o <= rt_data_i;
				ex_aluop_o   <= pl.aluop;
				ex_wren_o    <= pl.wren;
				ex_waddr_o   <= waddr_i;
				ex_exc_o     <= pl.exc;
				ex_has_exc_o <= |pl.exc;
				ex_ov_inst_o <= pl.ov_inst;
			end
		end
	end

endmodule

//--- id_stage_top.sv
`timescale 1ns/1ps

module id_stage_top (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              stall_i,
	input  logic              flush_i,
	input  logic              valid_i,
	input  logic              fetch_exc_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     rs_data_i,
	input  id_pkg::word_t     rt_data_i,
	output id_pkg::reg_addr_t rs_addr_o,
	output id_pkg::reg_addr_t rt_addr_o,
	output logic              rs_ren_o,
	output logic              rt_ren_o,
	output logic              branch_en_o,
	output id_pkg::word_t     branch_pc_o,
	output logic              ex_valid_o,
	output id_pkg::word_t     ex_pc_o,
	output id_pkg::word_t     ex_opr1_o,
	output id_pkg::word_t     ex_opr2_o,
	output id_pkg::word_t     ex_rtvalue_o,
	output id_pkg::alu_op_e   ex_aluop_o,
	output logic              ex_wren_o,
	output id_pkg::reg_addr_t ex_waddr_o,
	output id_pkg::exc_t      ex_exc_o,
	output logic              ex_has_exc_o,
	output logic              ex_ov_inst_o
);

	id_pkg::word_t     opr1;
	id_pkg::word_t     opr2;
	id_pkg::reg_addr_t waddr;

	id_ctrl_if ctrl_if ();

	// regfile read ports
	assign rs_addr_o = inst_i[25:21];
	assign rt_addr_o = inst_i[20:16];

	id_control control_i (
		.inst_i      (inst_i),
		.valid_i     (valid_i),
		.fetch_exc_i (fetch_exc_i),
		.rs_ren_o    (rs_ren_o),
		.rt_ren_o    (rt_ren_o),
		.ctrl        (ctrl_if.ctrl)
	);

	id_operand_select operand_select_i (
		.inst_i    (inst_i),
		.pc_i      (pc_i),
		.rs_data_i (rs_data_i),
		.rt_data_i (rt_data_i),
		.sel       (ctrl_if.opsel),
		.opr1_o    (opr1),
		.opr2_o    (opr2),
		.waddr_o   (waddr)
	);

	id_branch_unit branch_unit_i (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.rs_data_i   (rs_data_i),
		.rt_data_i   (rt_data_i),
		.br          (ctrl_if.branch),
		.branch_en_o (branch_en_o),
		.branch_pc_o (branch_pc_o)
	);

	id_pipe_reg pipe_reg_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.stall_i      (stall_i),
		.flush_i      (flush_i),
		.valid_i      (valid_i),
		.pc_i         (pc_i),
		.opr1_i       (opr1),
		.opr2_i       (opr2),
		.rt_data_i    (rt_data_i),
		.waddr_i      (waddr),
		.pl           (ctrl_if.pipe),
		.ex_valid_o   (ex_valid_o),
		.ex_pc_o      (ex_pc_o),
		.ex_opr1_o    (ex_opr1_o),
		.ex_opr2_o    (ex_opr2_o),
		.ex_rtvalue_o (ex_rtvalue_o),
		.ex_aluop_o   (ex_aluop_o),
		.ex_wren_o    (ex_wren_o),
		.ex_waddr_o   (ex_waddr_o),
		.ex_exc_o     (ex_exc_o),
		.ex_has_exc_o (ex_has_exc_o),
		.ex_ov_inst_o (ex_ov_inst_o)
	);

endmodule

//--- id_stage_properties.sv
`timescale 1ns/1ps

module id_stage_properties (
	input logic              clk_i,
	input logic              rst_n_i,
	input logic              stall_i,
	input logic              flush_i,
	input logic              ex_valid_i,
	input id_pkg::word_t     ex_pc_i,
	input id_pkg::word_t     ex_opr1_i,
	input id_pkg::word_t     ex_opr2_i,
	input id_pkg::word_t     ex_rtvalue_i,
	input id_pkg::alu_op_e   ex_aluop_i,
	input logic              ex_wren_i,
	input id_pkg::reg_addr_t ex_waddr_i,
	input id_pkg::exc_t      ex_exc_i,
	input logic              ex_has_exc_i,
	input logic              ex_ov_inst_i
);

	int fail_count = 0;

	// whole ex register is clear while reset is held
	reset_clear: assert property (@(posedge clk_i) !rst_n_i |->
		({ex_valid_i, ex_pc_i, ex_opr1_i, ex_opr2_i, ex_rtvalue_i, ex_aluop_i,
		  ex_wren_i, ex_waddr_i, ex_exc_i, ex_has_exc_i, ex_ov_inst_i} == '0))
		else begin
			fail_count++;
			$error("ex outputs not zero during reset");
		end

	flush_kills: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(flush_i && !stall_i) |=> (!ex_valid_i && !ex_wren_i))
		else begin
			fail_count++;
			$error("flush did not clear ex_valid_o and ex_wren_o");
		end

	stall_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> $stable(ex_pc_i))
		else begin
			fail_count++;
			$error("ex_pc_o changed during a stall");
		end

endmodule

//--- tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

	localparam int RESET_CYCLES = 8;
	localparam int TEST_LEN     = 300;
	localparam int NUM_TESTS    = 6;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TESTS * TEST_LEN + 50;

	// six bits per entry
	localparam logic [59:0] ALU_FNS = {id_pkg::F_ADD, id_pkg::F_ADDU, id_pkg::F_SUB,
		id_pkg::F_SUBU, id_pkg::F_AND, id_pkg::F_OR, id_pkg::F_XOR, id_pkg::F_NOR,
		id_pkg::F_SLT, id_pkg::F_SLTU};
	localparam logic [35:0] SHIFT_FNS = {id_pkg::F_SLL, id_pkg::F_SRL, id_pkg::F_SRA,
		id_pkg::F_SLLV, id_pkg::F_SRLV, id_pkg::F_SRAV};
	localparam logic [47:0] BR_OPS = {id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_BLEZ,
		id_pkg::OP_BGTZ, id_pkg::OP_REGIMM, id_pkg::OP_J, id_pkg::OP_JAL, id_pkg::OP_SPECIAL};

	typedef struct packed {
		logic              valid;
		id_pkg::word_t     pc;
		id_pkg::word_t     opr1;
		id_pkg::word_t     opr2;
		id_pkg::word_t     rtv;
		id_pkg::alu_op_e   aluop;
		logic              wren;
		id_pkg::reg_addr_t waddr;
		id_pkg::exc_t      exc;
		logic              has_exc;
		logic              ov;
		logic              care;  // operand fields defined
	} ex_img_t;

	logic              clk;
	logic              rst_n_i;
	logic              stall_i;
	logic              flush_i;
	logic              valid_i;
	logic              fetch_exc_i;
	id_pkg::word_t     pc_i;
	id_pkg::word_t     inst_i;
	id_pkg::word_t     rs_data_i;
	id_pkg::word_t     rt_data_i;
	id_pkg::reg_addr_t rs_addr_o;
	id_pkg::reg_addr_t rt_addr_o;
	logic              rs_ren_o;
	logic              rt_ren_o;
	logic              branch_en_o;
	id_pkg::word_t     branch_pc_o;
	logic              ex_valid_o;
	id_pkg::word_t     ex_pc_o;
	id_pkg::word_t     ex_opr1_o;
	id_pkg::word_t     ex_opr2_o;
	id_pkg::word_t     ex_rtvalue_o;
	id_pkg::alu_op_e   ex_aluop_o;
	logic              ex_wren_o;
	id_pkg::reg_addr_t ex_waddr_o;
	id_pkg::exc_t      ex_exc_o;
	logic              ex_has_exc_o;
	logic              ex_ov_inst_o;

	logic [31:0]   lfsr = 32'd29;
	int            errors = 0;
	int            checks = 0;
	int            cycles = 0;
	ex_img_t       exp_img;
	ex_img_t       next_img;  // decode of the inputs now applied
	id_pkg::word_t cur_inst;
	id_pkg::word_t cur_pc;
	id_pkg::word_t cur_rs;
	id_pkg::word_t cur_rt;
	logic          cur_valid;
	logic          cur_fe;
	logic          cur_stall;
	logic          cur_flush;

	id_stage_top dut_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.stall_i      (stall_i),
		.flush_i      (flush_i),
		.valid_i      (valid_i),
		.fetch_exc_i  (fetch_exc_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.rs_data_i    (rs_data_i),
		.rt_data_i    (rt_data_i),
		.rs_addr_o    (rs_addr_o),
		.rt_addr_o    (rt_addr_o),
		.rs_ren_o     (rs_ren_o),
		.rt_ren_o     (rt_ren_o),
		.branch_en_o  (branch_en_o),
		.branch_pc_o  (branch_pc_o),
		.ex_valid_o   (ex_valid_o),
		.ex_pc_o      (ex_pc_o),
		.ex_opr1_o    (ex_opr1_o),
		.ex_opr2_o    (ex_opr2_o),
		.ex_rtvalue_o (ex_rtvalue_o),
		.ex_aluop_o   (ex_aluop_o),
		.ex_wren_o    (ex_wren_o),
		.ex_waddr_o   (ex_waddr_o),
		.ex_exc_o     (ex_exc_o),
		.ex_has_exc_o (ex_has_exc_o),
		.ex_ov_inst_o (ex_ov_inst_o)
	);

	bind id_stage_top id_stage_properties props_i (
		.clk_i        (clk),
		.rst_n_i      (rst_n_i),
		.stall_i      (stall_i),
		.flush_i      (flush_i),
		.ex_valid_i   (ex_valid_o),
		.ex_pc_i      (ex_pc_o),
		.ex_opr1_i    (ex_opr1_o),
		.ex_opr2_i    (ex_opr2_o),
		.ex_rtvalue_i (ex_rtvalue_o),
		.ex_aluop_i   (ex_aluop_o),
		.ex_wren_i    (ex_wren_o),
		.ex_waddr_i   (ex_waddr_o),
		.ex_exc_i     (ex_exc_o),
		.ex_has_exc_i (ex_has_exc_o),
		.ex_ov_inst_i (ex_ov_inst_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic id_pkg::word_t lfsr_bits(input int n);
		id_pkg::word_t v;
		logic          fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic ex_img_t flushed_image();
		ex_img_t z;
		z      = '0;
		z.care = 1'b1;
		return z;
	endfunction

	task automatic check_word(input string name, input id_pkg::word_t got,
		input id_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input id_pkg::reg_addr_t got,
		input id_pkg::reg_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_aluop(input string name, input id_pkg::alu_op_e got,
		input id_pkg::alu_op_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_exc(input string name, input id_pkg::exc_t got,
		input id_pkg::exc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
		end
	endtask

	task automatic build_inst(input int mode, output id_pkg::word_t inst);
		id_pkg::opcode_t   op;
		id_pkg::funct_t    fn;
		id_pkg::reg_addr_t rs;
		id_pkg::reg_addr_t rt;
		id_pkg::reg_addr_t rd;
		id_pkg::reg_addr_t sa;
		logic [1:0]        pick;
		int                m;
		m  = mode;
		op = id_pkg::OP_SPECIAL;
		rs = 5'(lfsr_bits(5));
		rt = 5'(lfsr_bits(5));
		rd = 5'(lfsr_bits(5));
		sa = 5'(lfsr_bits(5));
		fn = 6'(lfsr_bits(6));
		if (m == 5) begin
			pick = 2'(lfsr_bits(2));
			if (pick == 2'd0) begin
				fn = lfsr_bits(1) ? id_pkg::F_BREAK : id_pkg::F_SYSCALL;
				m  = -1;
			end else if (pick == 2'd1) begin
				m = -2;  // raw word
			end else begin
				m = int'(lfsr_bits(3) % 5);
			end
		end
		case (m)
		0: begin
			fn = ALU_FNS[(lfsr_bits(4) % 10) * 6 +: 6];
			sa = '0;
		end
		1: begin
			op = 6'(id_pkg::OP_ADDI + lfsr_bits(3));
			if (op == id_pkg::OP_LUI && lfsr_bits(3) != 0)
				rs = '0;
		end
		2: begin
			fn = SHIFT_FNS[(lfsr_bits(3) % 6) * 6 +: 6];
			if (fn[2])
				sa = '0;
			else
				rs = '0;
		end
		3: begin
			op   = BR_OPS[lfsr_bits(3) * 6 +: 6];
			pick = 2'(lfsr_bits(2));
			if (op == id_pkg::OP_SPECIAL) begin
				fn = pick[0] ? id_pkg::F_JALR : id_pkg::F_JR;
				rt = '0;
				sa = '0;
				if (!pick[0])
					rd = '0;
			end else if (op == id_pkg::OP_REGIMM) begin
				rt = {pick[1], 3'b000, pick[0]};
			end else if (op == id_pkg::OP_BLEZ || op == id_pkg::OP_BGTZ) begin
				rt = '0;
			end
		end
		4: begin
			pick = 2'(lfsr_bits(2));
			if (pick == 2'd0) begin
				op = id_pkg::OP_JAL;
			end else if (pick == 2'd1) begin
				fn = id_pkg::F_JALR;
				rt = '0;
				sa = '0;
			end else begin
				op = id_pkg::OP_REGIMM;
				rt = {1'b1, 3'b000, pick[0]};  // bltzal or bgezal
			end
		end
		default: ;
		endcase
		inst = (m == -2) ? lfsr_bits(32) : {op, rs, rt, rd, sa, fn};
	endtask

	task automatic drive_random(input int mode);
		build_inst(mode, cur_inst);
		cur_pc    = lfsr_bits(30) << 2;
		cur_rs    = (lfsr_bits(3) == 0) ? '0 : lfsr_bits(32);
		cur_rt    = (lfsr_bits(2) == 0) ? cur_rs : lfsr_bits(32);  // equal pairs
		cur_valid = (lfsr_bits(3) != 0);
		cur_fe    = (lfsr_bits(4) == 0);
		cur_stall = (lfsr_bits(mode == 5 ? 2 : 3) == 0);
		cur_flush = (lfsr_bits(mode == 5 ? 2 : 3) == 0);
		inst_i      <= cur_inst;
		pc_i        <= cur_pc;
		rs_data_i   <= cur_rs;
		rt_data_i   <= cur_rt;
		valid_i     <= cur_valid;
		fetch_exc_i <= cur_fe;
		stall_i     <= cur_stall;
		flush_i     <= cur_flush;
	endtask

	// reference decode of the inputs now applied
	task automatic predict(output ex_img_t img, output logic rs_ren, output logic rt_ren,
		output logic br_en, output id_pkg::word_t br_pc);
		id_pkg::opcode_t   op;
		id_pkg::funct_t    fn;
		id_pkg::reg_addr_t rs;
		id_pkg::reg_addr_t rt;
		id_pkg::reg_addr_t rd;
		id_pkg::reg_addr_t sa;
		logic              known;
		logic              wr;
		logic              link;
		logic              ov;
		logic              sys;
		logic              brk;
		logic              is_br;
		logic              take;
		logic              lez;
		id_pkg::word_t     imm_s;
		id_pkg::word_t     pcp4;
		id_pkg::word_t     target;
		op     = cur_inst[31:26];
		rs     = cur_inst[25:21];
		rt     = cur_inst[20:16];
		rd     = cur_inst[15:11];
		sa     = cur_inst[10:6];
		fn     = cur_inst[5:0];
		imm_s  = {{16{cur_inst[15]}}, cur_inst[15:0]};
		pcp4   = cur_pc + 32'd4;
		target = pcp4 + (imm_s << 2);
		lez    = cur_rs[31] || (cur_rs == '0);
		known  = 1'b1;
		wr     = 1'b1;
		link   = 1'b0;
		ov     = 1'b0;
		sys    = 1'b0;
		brk    = 1'b0;
		is_br  = 1'b0;
		take   = 1'b0;
		rs_ren = 1'b1;
		rt_ren = 1'b0;
		img       = '0;
		img.aluop = id_pkg::ALU_ADD;
		img.opr1  = cur_rs;
		img.opr2  = cur_rt;
		img.waddr = rd;
		case (op)
		id_pkg::OP_SPECIAL: begin
			rt_ren = 1'b1;
			known  = (sa == '0);
			case (fn)
			id_pkg::F_ADD, id_pkg::F_ADDU: ov = (fn == id_pkg::F_ADD);
			id_pkg::F_SUB, id_pkg::F_SUBU: begin
				img.aluop = id_pkg::ALU_SUB;
				ov        = (fn == id_pkg::F_SUB);
			end
			id_pkg::F_SLT:  img.aluop = id_pkg::ALU_SLT;
			id_pkg::F_SLTU: img.aluop = id_pkg::ALU_SLTU;
			id_pkg::F_AND:  img.aluop = id_pkg::ALU_AND;
			id_pkg::F_OR:   img.aluop = id_pkg::ALU_OR;
			id_pkg::F_XOR:  img.aluop = id_pkg::ALU_XOR;
			id_pkg::F_NOR:  img.aluop = id_pkg::ALU_NOR;
			id_pkg::F_SLL, id_pkg::F_SRL, id_pkg::F_SRA,
			id_pkg::F_SLLV, id_pkg::F_SRLV, id_pkg::F_SRAV: begin
				if (fn == id_pkg::F_SLL || fn == id_pkg::F_SLLV)
					img.aluop = id_pkg::ALU_SLL;
				else if (fn == id_pkg::F_SRL || fn == id_pkg::F_SRLV)
					img.aluop = id_pkg::ALU_SRL;
				else
					img.aluop = id_pkg::ALU_SRA;
				if (fn == id_pkg::F_SLL || fn == id_pkg::F_SRL || fn == id_pkg::F_SRA) begin
					known    = (rs == '0);
					rs_ren   = 1'b0;
					img.opr1 = {27'h0, sa};
				end
			end
			id_pkg::F_JR, id_pkg::F_JALR: begin
				known  = (sa == '0) && (rt == '0) && (rd == '0 || fn == id_pkg::F_JALR);
				rt_ren = 1'b0;
				wr     = 1'b0;
				link   = (fn == id_pkg::F_JALR);
				is_br  = 1'b1;
				take   = 1'b1;
				target = cur_rs;
			end
			id_pkg::F_SYSCALL, id_pkg::F_BREAK: begin
				known  = 1'b1;  // code field is free
				rs_ren = 1'b0;
				rt_ren = 1'b0;
				wr     = 1'b0;
				sys    = (fn == id_pkg::F_SYSCALL);
				brk    = !sys;
			end
			default: known = 1'b0;
			endcase
		end
		id_pkg::OP_REGIMM: begin
			wr        = 1'b0;
			is_br     = 1'b1;
			img.waddr = id_pkg::LINK_REG;
			known     = (rt == id_pkg::RT_BLTZ || rt == id_pkg::RT_BGEZ ||
				rt == id_pkg::RT_BLTZAL || rt == id_pkg::RT_BGEZAL);
			link      = (rt == id_pkg::RT_BLTZAL || rt == id_pkg::RT_BGEZAL);
			take      = (rt == id_pkg::RT_BGEZ || rt == id_pkg::RT_BGEZAL) ?
				!cur_rs[31] : cur_rs[31];
		end
		id_pkg::OP_J, id_pkg::OP_JAL: begin
			rs_ren    = 1'b0;
			wr        = 1'b0;
			link      = (op == id_pkg::OP_JAL);
			img.waddr = id_pkg::LINK_REG;
			is_br     = 1'b1;
			take      = 1'b1;
			target    = {pcp4[31:28], cur_inst[25:0], 2'b00};
		end
		id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
			rt_ren = 1'b1;
			wr     = 1'b0;
			is_br  = 1'b1;
			take   = ((op == id_pkg::OP_BEQ) == (cur_rs == cur_rt));
		end
		id_pkg::OP_BLEZ, id_pkg::OP_BGTZ: begin
			known = (rt == '0);
			wr    = 1'b0;
			is_br = 1'b1;
			take  = ((op == id_pkg::OP_BLEZ) == lez);
		end
		id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
			img.opr2  = imm_s;
			img.waddr = rt;
			ov        = (op == id_pkg::OP_ADDI);
			if (op == id_pkg::OP_SLTI)
				img.aluop = id_pkg::ALU_SLT;
			else if (op == id_pkg::OP_SLTIU)
				img.aluop = id_pkg::ALU_SLTU;
		end
		id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI: begin
			img.opr2  = {16'h0, cur_inst[15:0]};
			img.waddr = rt;
			if (op == id_pkg::OP_ANDI)
				img.aluop = id_pkg::ALU_AND;
			else if (op == id_pkg::OP_ORI)
				img.aluop = id_pkg::ALU_OR;
			else
				img.aluop = id_pkg::ALU_XOR;
		end
		id_pkg::OP_LUI: begin
			known     = (rs == '0);
			rs_ren    = 1'b0;
			img.opr2  = {cur_inst[15:0], 16'h0};
			img.waddr = rt;
			img.aluop = id_pkg::ALU_LUI;
		end
		default: known = 1'b0;
		endcase
		if (link) begin  // return address is pc + 8
			img.opr1 = cur_pc;
			img.opr2 = id_pkg::LINK_OFFSET;
		end
		rs_ren      = rs_ren && known;
		rt_ren      = rt_ren && known;
		img.valid   = cur_valid;
		img.pc      = cur_pc;
		img.rtv     = cur_rt;
		img.wren    = cur_valid && known && (wr || link);
		img.ov      = cur_valid && known && ov;
		img.exc[id_pkg::EXC_FETCH]   = cur_valid && cur_fe;
		img.exc[id_pkg::EXC_SYSCALL] = cur_valid && known && sys;
		img.exc[id_pkg::EXC_BREAK]   = cur_valid && known && brk;
		img.exc[id_pkg::EXC_RI]      = cur_valid && !known;
		img.has_exc = |img.exc;
		img.care    = known;
		br_en = cur_valid && known && is_br && take;
		br_pc = (cur_valid && known && is_br) ? target : '0;
	endtask

	task automatic check_ex_outputs();
		check_bit("ex_valid_o", ex_valid_o, exp_img.valid);
		check_word("ex_pc_o", ex_pc_o, exp_img.pc);
		check_word("ex_rtvalue_o", ex_rtvalue_o, exp_img.rtv);
		check_bit("ex_wren_o", ex_wren_o, exp_img.wren);
		check_exc("ex_exc_o", ex_exc_o, exp_img.exc);
		check_bit("ex_has_exc_o", ex_has_exc_o, exp_img.has_exc);
		check_bit("ex_ov_inst_o", ex_ov_inst_o, exp_img.ov);
		if (exp_img.care) begin
			check_word("ex_opr1_o", ex_opr1_o, exp_img.opr1);
			check_word("ex_opr2_o", ex_opr2_o, exp_img.opr2);
			check_aluop("ex_aluop_o", ex_aluop_o, exp_img.aluop);
			check_addr("ex_waddr_o", ex_waddr_o, exp_img.waddr);
		end
	endtask

	task automatic run_test(input int mode, input string name);
		int            start_errors;
		logic          rs_ren;
		logic          rt_ren;
		logic          br_en;
		id_pkg::word_t br_pc;
		start_errors = errors;
		repeat (TEST_LEN) begin
			@(posedge clk);
			if (!cur_stall)
				exp_img = cur_flush ? flushed_image() : next_img;
			drive_random(mode);
			@(negedge clk);
			predict(next_img, rs_ren, rt_ren, br_en, br_pc);
			check_addr("rs_addr_o", rs_addr_o, cur_inst[25:21]);
			check_addr("rt_addr_o", rt_addr_o, cur_inst[20:16]);
			check_bit("rs_ren_o", rs_ren_o, rs_ren);
			check_bit("rt_ren_o", rt_ren_o, rt_ren);
			check_bit("branch_en_o", branch_en_o, br_en);
			check_word("branch_pc_o", branch_pc_o, br_pc);
			check_ex_outputs();
		end
		$display("test %0d (%s): %0d cycles, %0d errors", mode, name, TEST_LEN,
			errors - start_errors);
	endtask

	initial begin
		logic          rs_ren;
		logic          rt_ren;
		logic          br_en;
		id_pkg::word_t br_pc;
		int            total_errors;
		rst_n_i     <= 1'b0;
		stall_i     <= 1'b0;
		flush_i     <= 1'b0;
		valid_i     <= 1'b0;
		fetch_exc_i <= 1'b0;
		pc_i        <= '0;
		inst_i      <= '0;
		rs_data_i   <= '0;
		rt_data_i   <= '0;
		cur_inst  = '0;
		cur_pc    = '0;
		cur_rs    = '0;
		cur_rt    = '0;
		cur_valid = 1'b0;
		cur_fe    = 1'b0;
		cur_stall = 1'b0;
		cur_flush = 1'b0;
		exp_img   = flushed_image();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		predict(next_img, rs_ren, rt_ren, br_en, br_pc);
		check_bit("rs_ren_o", rs_ren_o, rs_ren);
		check_bit("rt_ren_o", rt_ren_o, rt_ren);
		check_bit("branch_en_o", branch_en_o, br_en);
		check_word("branch_pc_o", branch_pc_o, br_pc);
		check_ex_outputs();
		run_test(0, "r-type alu");
		run_test(1, "immediate");
		run_test(2, "shift");
		run_test(3, "branch and jump");
		run_test(4, "link");
		run_test(5, "exception stall flush");
		total_errors = errors + dut_i.props_i.fail_count;
		$display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
			NUM_TESTS, checks, errors, dut_i.props_i.fail_count);
		if (total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

endmodule

//--- filelist.f
id_pkg.sv
id_ctrl_if.sv
id_control.sv
id_operand_select.sv
id_branch_unit.sv
id_pipe_reg.sv
id_stage_top.sv
id_stage_properties.sv
tb_id_stage.sv
